// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+dv
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_if.sv
design/interrupt_storage.sv
design/stage_fetch.sv
design/fetch_queue.sv
design/stage_execute.sv
design/core.sv
dv/core_tb.sv

// ==== design/core.sv ====
`timescale 1ns/1ps

module core #(
    parameter int QUEUE_DEPTH = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::int_vec_t external_interrupt,
    output logic               ins_read,
    output logic [31:0]        ins_addr,
    input  logic [31:0]        ins_data,
    input  logic               ins_busy,
    output logic               wb_valid,
    output logic [4:0]         wb_reg,
    output logic [31:0]        wb_data,
    output logic [31:0]        wb_pc,
    output logic               exc_taken,
    output logic [31:0]        exc_epc
);
    import core_pkg::*;

    fetch_if f2q (.clk(clk));
    fetch_if q2e (.clk(clk));

    logic        load;      // Redirect pulse from execute
    logic [31:0] pc_load;
    logic        accept;
    int_vec_t    int_pending;

    interrupt_storage #(.SYNC_STAGES(SYNC_STAGES)) unit_interrupt (
        .clk(clk), .rst_n(rst_n), .irq(external_interrupt),
        .clear(accept), .pending(int_pending));

    stage_fetch unit_fetch (
        .clk(clk), .rst_n(rst_n), .load(load), .pc_load(pc_load),
        .ins_read(ins_read), .ins_addr(ins_addr),
        .ins_data(ins_data), .ins_busy(ins_busy),
        .fq(f2q.producer));

    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) unit_queue (
        .clk(clk), .rst_n(rst_n), .flush(load),
        .wr(f2q.buffer_in), .rd(q2e.buffer_out));

    stage_execute unit_execute (
        .clk(clk), .rst_n(rst_n), .eq(q2e.consumer),
        .int_pending(int_pending), .accept(accept),
        .load(load), .pc_load(pc_load),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .wb_pc(wb_pc),
        .exc_taken(exc_taken), .exc_epc(exc_epc));

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

    // ========================================================================
    // Pipeline configuration
    // ========================================================================

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;

    // Fetch target on interrupt entry
    localparam logic [31:0] EXC_VECTOR = 32'h0000_0180;

    // External interrupt lines
    localparam int N_INT = 5;

    typedef logic [N_INT-1:0] int_vec_t;

endpackage

// ==== design/fetch_if.sv ====
`timescale 1ns/1ps

// One fetched word with its PC, moved when valid && !stall
interface fetch_if (
    input logic clk
);
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic        stall;

    modport producer (
        input  clk, stall,
        output valid, pc, instruction
    );
    modport buffer_in (
        input  clk, valid, pc, instruction,
        output stall
    );
    modport buffer_out (
        input  clk, stall,
        output valid, pc, instruction
    );
    modport consumer (
        input  clk, valid, pc, instruction,
        output stall
    );
endinterface

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    fetch_if.buffer_in  wr,
    fetch_if.buffer_out rd
);
    localparam int AW = $clog2(QUEUE_DEPTH);

    logic [31:0] pc_mem  [QUEUE_DEPTH];
    logic [31:0] ins_mem [QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [AW:0]   count;
    logic          full, push, pop;

    assign full        = count == (AW+1)'(QUEUE_DEPTH);
    assign push        = wr.valid && !full;
    assign pop         = rd.valid && !rd.stall;
    assign wr.stall    = full;
    assign rd.valid    = count != '0;
    assign rd.pc          = pc_mem[rd_ptr];
    assign rd.instruction = ins_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            pc_mem[wr_ptr]  <= wr.pc;
            ins_mem[wr_ptr] <= wr.instruction;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (AW+1)'(QUEUE_DEPTH));

    // A word refused while full is still offered next cycle
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr.valid && full && !flush |=> wr.valid && $stable(wr.instruction));

endmodule

// ==== design/interrupt_storage.sv ====
`timescale 1ns/1ps

module interrupt_storage #(
    parameter int SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::int_vec_t irq,
    input  logic               clear,
    output core_pkg::int_vec_t pending
);
    import core_pkg::*;

    int_vec_t sync_q [SYNC_STAGES];
    int_vec_t prev_q;           // Last synchronized level, for edge detect
    int_vec_t rise;

    assign rise = sync_q[SYNC_STAGES-1] & ~prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            prev_q  <= '0;
            pending <= '0;
        end else begin
            sync_q[0] <= irq;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            prev_q <= sync_q[SYNC_STAGES-1];
            if (clear) begin
                pending <= '0;  // An edge landing here is lost
            end else begin
                pending <= pending | rise;
            end
        end
    end

    a_clear_empties: assert property (@(posedge clk) disable iff (!rst_n)
        clear |=> pending == '0);

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] reg_idx_t;

    // ========================================================================
    // Instruction formats
    // ========================================================================
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } instr_r_t;

    typedef struct packed {
        opcode_t  op;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm16;
    } instr_i_t;

    // One fetched word, seen as R-type or I-type
    typedef union packed {
        instr_r_t    r;
        instr_i_t    i;
        logic [31:0] raw;
    } instr_u;

    // Opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;

    // SPECIAL funct field
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

// ==== design/stage_execute.sv ====
`timescale 1ns/1ps

module stage_execute (
    input  logic               clk,
    input  logic               rst_n,
    fetch_if.consumer          eq,
    input  core_pkg::int_vec_t int_pending,
    output logic               accept,
    output logic               load,
    output logic [31:0]        pc_load,
    output logic               wb_valid,
    output logic [4:0]         wb_reg,
    output logic [31:0]        wb_data,
    output logic [31:0]        wb_pc,
    output logic               exc_taken,
    output logic [31:0]        exc_epc
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [31:0] rf [32];
    instr_u      ins;
    logic [31:0] rs_val, rt_val, imm_sext, result;
    reg_idx_t    dst;
    logic        armed;     // Cleared on entry, set again by a retirement
    logic        take_int, pop;

    assign take_int = eq.valid && armed && (int_pending != '0) && !load;
    assign eq.stall = take_int || load;
    assign pop      = eq.valid && !eq.stall;
    assign pc_load  = EXC_VECTOR;

    // ========================================================================
    // Decode and ALU
    // ========================================================================
    always_comb begin
        ins.raw  = eq.instruction;
        rs_val   = (ins.r.rs == 5'd0) ? 32'd0 : rf[ins.r.rs];
        rt_val   = (ins.r.rt == 5'd0) ? 32'd0 : rf[ins.r.rt];
        imm_sext = {{16{ins.i.imm16[15]}}, ins.i.imm16};
        dst      = '0;
        result   = '0;
        case (ins.r.op)
            OP_SPECIAL: begin
                dst = ins.r.rd;
                case (ins.r.funct)
                    FN_ADDU: result = rs_val + rt_val;
                    FN_SUBU: result = rs_val - rt_val;
                    FN_AND:  result = rs_val & rt_val;
                    FN_OR:   result = rs_val | rt_val;
                    FN_XOR:  result = rs_val ^ rt_val;
                    FN_SLT:  result = {31'd0, $signed(rs_val) < $signed(rt_val)};
                    default: dst = '0;  // Unknown funct retires as a no-op
                endcase
            end
            OP_ADDIU: begin
                dst    = ins.i.rt;
                result = rs_val + imm_sext;
            end
            OP_ORI: begin
                dst    = ins.i.rt;
                result = rs_val | {16'd0, ins.i.imm16};
            end
            OP_LUI: begin
                dst    = ins.i.rt;
                result = {ins.i.imm16, 16'd0};
            end
            default: ;
        endcase
        if (dst == 5'd0) result = '0;   // r0 reports zero
    end

    // ========================================================================
    // Retire and interrupt entry
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            exc_taken <= 1'b0;
            load      <= 1'b0;
            accept    <= 1'b0;
            armed     <= 1'b1;
        end else begin
            wb_valid  <= pop;
            exc_taken <= take_int;
            load      <= take_int;
            accept    <= take_int;
            if (take_int)  armed <= 1'b0;
            else if (pop)  armed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb_reg  <= dst;
            wb_data <= result;
            wb_pc   <= eq.pc;
            if (dst != 5'd0) rf[dst] <= result;
        end
        if (take_int) exc_epc <= eq.pc;     // Head is skipped, resumes later
    end

    a_retire_or_trap: assert property (@(posedge clk) disable iff (!rst_n)
        !(exc_taken && wb_valid));

endmodule

// ==== design/stage_fetch.sv ====
`timescale 1ns/1ps

module stage_fetch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic [31:0] pc_load,
    output logic        ins_read,
    output logic [31:0] ins_addr,
    input  logic [31:0] ins_data,
    input  logic        ins_busy,
    fetch_if.producer   fq
);
    import core_pkg::*;

    logic [31:0] pc;
    logic        running;   // Goes high one cycle after reset
    logic        hold;      // Request kept open by ins_busy
    logic        take;

    // A fresh request needs room downstream, a held one is kept regardless
    assign ins_read = running && !load && (hold || !fq.stall);
    assign ins_addr = pc;
    assign take     = ins_read && !ins_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            running  <= 1'b0;
            hold     <= 1'b0;
            fq.valid <= 1'b0;
        end else begin
            running <= 1'b1;
            hold    <= ins_read && ins_busy;
            if (load) begin
                pc       <= pc_load;    // Outstanding request dropped
                fq.valid <= 1'b0;
            end else if (take) begin
                pc       <= pc + 32'd4;
                fq.valid <= 1'b1;
            end else if (!fq.stall) begin
                fq.valid <= 1'b0;       // Word went into the queue
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (take) begin
            fq.pc          <= pc;
            fq.instruction <= ins_data;
        end
    end

    // ROM request must not move under a busy slave
    a_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        ins_read && ins_busy |=> (ins_read || load) && $stable(ins_addr));

endmodule

// ==== dv/core_tb_model.svh ====
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

typedef struct packed {
    logic [4:0]  idx;
    logic [31:0] data;
} wb_t;

// ============================================================================
// Reference model
// ============================================================================
function automatic wb_t predict(input logic [31:0] word, input logic [31:0] regs [32]);
    wb_t         r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a   = regs[word[25:21]];
    b   = regs[word[20:16]];
    imm = {{16{word[15]}}, word[15:0]};
    r   = '0;
    if (word[31:26] == OP_SPECIAL) begin
        r.idx = word[15:11];
        case (word[5:0])
            FN_ADDU: r.data = a + b;
            FN_SUBU: r.data = a - b;
            FN_AND:  r.data = a & b;
            FN_OR:   r.data = a | b;
            FN_XOR:  r.data = a ^ b;
            FN_SLT:  r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r.idx = 5'd0;
        endcase
    end else if (word[31:26] == OP_ADDIU) begin
        r.idx  = word[20:16];
        r.data = a + imm;
    end else if (word[31:26] == OP_ORI) begin
        r.idx  = word[20:16];
        r.data = a | {16'd0, word[15:0]};
    end else if (word[31:26] == OP_LUI) begin
        r.idx  = word[20:16];
        r.data = {word[15:0], 16'd0};
    end
    if (r.idx == 5'd0) r.data = '0;    // r0 stays zero
    return r;
endfunction

// ADDIU r<idx>, r0, imm
function automatic logic [31:0] prologue_word(input int idx);
    return {OP_ADDIU, 5'd0, 5'(idx), 16'($urandom())};
endfunction

function automatic logic [31:0] random_word();
    logic [31:0] w;
    int          k;
    w = $urandom();
    k = int'($urandom_range(9, 0));
    if (k < 6) begin
        w[31:26] = OP_SPECIAL;
        w[10:6]  = 5'd0;
        case (k)
            0:       w[5:0] = FN_ADDU;
            1:       w[5:0] = FN_SUBU;
            2:       w[5:0] = FN_AND;
            3:       w[5:0] = FN_OR;
            4:       w[5:0] = FN_XOR;
            default: w[5:0] = FN_SLT;
        endcase
    end else if (k == 6) begin
        w[31:26] = OP_ADDIU;
    end else if (k == 7) begin
        w[31:26] = OP_ORI;
    end else if (k == 8) begin
        w[31:26] = OP_LUI;
        w[25:21] = 5'd0;
    end else begin
        w[31:26] = w[0] ? 6'h23 : 6'h04;  // lw or beq, both no-ops here
    end
    return w;
endfunction

`endif

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    `include "core_tb_model.svh"

    localparam int N_PROLOGUE  = 31;
    localparam int N_STREAM    = 40;
    localparam int N_AFTER     = 20;
    localparam int TOTAL_INSTR = N_PROLOGUE + 2 * N_STREAM + 4 * N_AFTER;
    localparam int ROM_WORDS   = 512;

    logic        clk = 1'b0;
    logic        rst_n;
    int_vec_t    external_interrupt;
    logic        ins_read;
    logic [31:0] ins_addr;
    logic [31:0] ins_data;
    logic        ins_busy;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic [31:0] wb_pc;
    logic        exc_taken;
    logic [31:0] exc_epc;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] model_rf [32];
    logic [31:0] exp_pc;
    logic        busy_en;
    logic        in_request;
    logic        prev_exc;
    int          wait_left;
    int          retire_count, exc_count, errors, checks;
    int          tests_run, tests_failed, test_err0, ex0, ex1;

    core #(.QUEUE_DEPTH(4), .SYNC_STAGES(2)) dut0 (
        .clk(clk), .rst_n(rst_n), .external_interrupt(external_interrupt),
        .ins_read(ins_read), .ins_addr(ins_addr), .ins_data(ins_data), .ins_busy(ins_busy),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .wb_pc(wb_pc),
        .exc_taken(exc_taken), .exc_epc(exc_epc));

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ========================================================================
    // ROM with random wait states
    // ========================================================================
    always @(negedge clk) begin
        if (!rst_n || !ins_read) begin
            ins_busy   = 1'b0;
            in_request = 1'b0;
        end else begin
            if (!in_request) begin
                in_request = 1'b1;
                wait_left  = busy_en ? int'($urandom_range(3, 0)) : 0;
            end
            ins_data = rom[ins_addr[10:2]];
            if (wait_left > 0) begin
                ins_busy = 1'b1;
                wait_left--;
            end else begin
                ins_busy   = 1'b0;     // Word taken at the next edge
                in_request = 1'b0;
            end
        end
    end

    // ========================================================================
    // Checker
    // ========================================================================
    always @(negedge clk) begin
        wb_t e;
        if (rst_n) begin
            if (wb_valid) begin
                check_value("wb_pc", wb_pc, exp_pc);
                e = predict(rom[exp_pc[10:2]], model_rf);
                check_value("wb_reg", 32'(wb_reg), 32'(e.idx));
                check_value("wb_data", wb_data, e.data);
                if (e.idx != 5'd0) model_rf[e.idx] = e.data;
                exp_pc = exp_pc + 32'd4;
                retire_count++;
            end
            if (exc_taken) begin
                if (prev_exc) begin
                    errors++;
                    $display("exc_taken stayed high for two cycles at %0t", $time);
                end
                check_value("exc_epc", exc_epc, exp_pc);
                exp_pc = EXC_VECTOR;    // Head instruction is skipped
                exc_count++;
            end
            prev_exc = exc_taken;
        end
    end

    task automatic wait_retired(input int target);
        int spent;
        int limit;
        spent = 0;
        limit = 40 * (target - retire_count) + 100;
        while (retire_count < target && spent < limit) begin
            @(negedge clk);
            spent++;
        end
        if (retire_count < target) begin
            errors++;
            $display("retirements stalled at %0d while waiting for %0d", retire_count, target);
        end
    endtask

    task automatic wait_exc();
        int spent;
        spent = 0;
        while (!exc_taken && spent < 200) begin
            @(negedge clk);
            spent++;
        end
        if (!exc_taken) begin
            errors++;
            $display("no exc_taken followed the interrupt pulse at %0t", $time);
        end
    endtask

    task automatic pulse_irq(input int_vec_t lines);
        external_interrupt = lines;
        repeat (2) @(negedge clk);
        external_interrupt = '0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_err0 = errors;
    endtask

    // Watchdog
    initial begin
        repeat (TOTAL_INSTR * 40) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", TOTAL_INSTR * 40);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he228_8f34));
        rst_n              = 1'b0;
        external_interrupt = '0;
        ins_data           = '0;
        ins_busy           = 1'b0;
        busy_en            = 1'b0;
        in_request         = 1'b0;
        prev_exc           = 1'b0;
        wait_left          = 0;
        exp_pc             = RESET_PC;
        {retire_count, exc_count, errors, checks} = '0;
        {tests_run, tests_failed, test_err0} = '0;
        for (int r = 0; r < 32; r++) model_rf[r] = '0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < N_PROLOGUE) ? prologue_word(i + 1) : random_word();
        end

        repeat (16) @(negedge clk);
        check_value("ins_read", 32'(ins_read), 32'd0);
        check_value("ins_addr", ins_addr, RESET_PC);
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        check_value("exc_taken", 32'(exc_taken), 32'd0);
        rst_n = 1'b1;
        wait_retired(N_PROLOGUE);
        end_test("reset pc and register setup");

        wait_retired(retire_count + N_STREAM);
        end_test("alu stream");

        busy_en = 1'b1;
        wait_retired(retire_count + N_STREAM);
        check_value("exc_taken count", 32'(exc_count), 32'd0);
        end_test("alu stream with rom stalls");

        busy_en = 1'b0;
        ex0 = exc_count;
        pulse_irq(5'b00001);
        wait_exc();
        wait_retired(retire_count + N_AFTER);
        check_value("exc_taken count", 32'(exc_count - ex0), 32'd1);
        end_test("single interrupt");

        busy_en = 1'b1;
        ex0 = exc_count;
        pulse_irq(5'b10101);
        wait_exc();
        pulse_irq(5'b00010);    // Arrives during the redirect
        wait_retired(retire_count + 2 * N_AFTER);
        check_value("exc_taken count", 32'(exc_count - ex0), 32'd2);
        ex1 = exc_count;
        wait_retired(retire_count + N_AFTER);
        check_value("exc_taken without interrupt", 32'(exc_count - ex1), 32'd0);
        end_test("several interrupts");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
